// ==== rtl/rv32_ex_pkg.sv ====
/* shared types for the RV32I execute stage
   word and index widths, decode enums and the structs passed between blocks */
package rv32_ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_IMMED  = 7'b0010011;
    localparam opcode_t OPC_REG    = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // encodings match funct3 of loads and stores
    typedef enum logic [2:0] {
        LB = 3'b000, LH = 3'b001, LW = 3'b010, LBU = 3'b100, LHU = 3'b101
    } load_t;

    typedef enum logic [2:0] {
        BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100,
        BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
    } branch_t;

    typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC} a_sel_t;
    // rs1 on port b pairs with the store offset on port a
    typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_U, B_RS1} b_sel_t;
    typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
    } fetch_ex_t;

    typedef struct packed {
        alu_op_t  alu_op;
        a_sel_t   a_sel;
        b_sel_t   b_sel;
        w_sel_t   w_sel;
        load_t    load_type;
        branch_t  branch_type;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_sb;
        word_t    imm_uj;
        word_t    imm_u;
        logic     wen;
        logic     dren;
        logic     dwen;
        logic     branch;
        logic     jump;
        logic     j_sel;
        logic     ifence;
        logic     halt;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        logic     ren;
        logic     wen;
    } dbus_req_t;

    typedef struct packed {
        logic  mal_l;
        logic  mal_s;
        logic  illegal;
        word_t badaddr;
    } except_t;

endpackage

// ==== rtl/control_unit.sv ====
/* RV32I decoder
   turns one instruction word into operand selects, flags and extended immediates */
`timescale 1ns/1ns

module control_unit (
    input  rv32_ex_pkg::word_t instr,
    output rv32_ex_pkg::ctrl_t ctrl
);

    rv32_ex_pkg::opcode_t opcode;
    rv32_ex_pkg::funct3_t funct3;
    rv32_ex_pkg::alu_op_t arith_op;
    logic                 is_reg;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign is_reg = (opcode == rv32_ex_pkg::OPC_REG);

    // funct7 bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg && instr[30]) ? rv32_ex_pkg::ALU_SUB
                                                      : rv32_ex_pkg::ALU_ADD;
            3'b001:  arith_op = rv32_ex_pkg::ALU_SLL;
            3'b010:  arith_op = rv32_ex_pkg::ALU_SLT;
            3'b011:  arith_op = rv32_ex_pkg::ALU_SLTU;
            3'b100:  arith_op = rv32_ex_pkg::ALU_XOR;
            3'b101:  arith_op = instr[30] ? rv32_ex_pkg::ALU_SRA : rv32_ex_pkg::ALU_SRL;
            3'b110:  arith_op = rv32_ex_pkg::ALU_OR;
            default: arith_op = rv32_ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl             = '0;
        ctrl.alu_op      = rv32_ex_pkg::ALU_ADD;
        ctrl.a_sel       = rv32_ex_pkg::A_RS1;
        ctrl.b_sel       = rv32_ex_pkg::B_RS2;
        ctrl.w_sel       = rv32_ex_pkg::W_ALU;
        ctrl.load_type   = rv32_ex_pkg::LW;
        ctrl.branch_type = rv32_ex_pkg::BEQ;
        ctrl.rs1         = instr[19:15];
        ctrl.rs2         = instr[24:20];
        ctrl.rd          = instr[11:7];

        ctrl.imm_i  = {{20{instr[31]}}, instr[31:20]};
        ctrl.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        ctrl.imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        ctrl.imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                       1'b0};
        ctrl.imm_u  = {instr[31:12], 12'b0};

        case (opcode)
            rv32_ex_pkg::OPC_LUI: begin
                ctrl.wen   = 1'b1;
                ctrl.w_sel = rv32_ex_pkg::W_IMM_U;
            end
            rv32_ex_pkg::OPC_AUIPC: begin
                ctrl.wen   = 1'b1;
                ctrl.a_sel = rv32_ex_pkg::A_PC;
                ctrl.b_sel = rv32_ex_pkg::B_IMM_U;
            end
            rv32_ex_pkg::OPC_JAL, rv32_ex_pkg::OPC_JALR: begin
                ctrl.wen   = 1'b1;
                ctrl.jump  = 1'b1;
                ctrl.j_sel = (opcode == rv32_ex_pkg::OPC_JAL);
                ctrl.w_sel = rv32_ex_pkg::W_PC4;
            end
            rv32_ex_pkg::OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl.branch_type = rv32_ex_pkg::BEQ;
                    3'b001:  ctrl.branch_type = rv32_ex_pkg::BNE;
                    3'b100:  ctrl.branch_type = rv32_ex_pkg::BLT;
                    3'b101:  ctrl.branch_type = rv32_ex_pkg::BGE;
                    3'b110:  ctrl.branch_type = rv32_ex_pkg::BLTU;
                    3'b111:  ctrl.branch_type = rv32_ex_pkg::BGEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            rv32_ex_pkg::OPC_LOAD, rv32_ex_pkg::OPC_STORE: begin
                ctrl.dren = (opcode == rv32_ex_pkg::OPC_LOAD);
                ctrl.dwen = (opcode == rv32_ex_pkg::OPC_STORE);
                ctrl.wen  = ctrl.dren;
                ctrl.w_sel = rv32_ex_pkg::W_LOAD;
                // store address is imm_s + rs1
                if (ctrl.dwen) begin
                    ctrl.a_sel = rv32_ex_pkg::A_IMM_S;
                    ctrl.b_sel = rv32_ex_pkg::B_RS1;
                end else begin
                    ctrl.b_sel = rv32_ex_pkg::B_IMM_I;
                end
                case (funct3)
                    3'b000:  ctrl.load_type = rv32_ex_pkg::LB;
                    3'b001:  ctrl.load_type = rv32_ex_pkg::LH;
                    3'b010:  ctrl.load_type = rv32_ex_pkg::LW;
                    3'b100:  ctrl.load_type = rv32_ex_pkg::LBU;
                    3'b101:  ctrl.load_type = rv32_ex_pkg::LHU;
                    default: ctrl.illegal = 1'b1;
                endcase
                // no unsigned stores
                if (ctrl.dwen && funct3[2]) begin
                    ctrl.illegal = 1'b1;
                end
            end
            rv32_ex_pkg::OPC_IMMED, rv32_ex_pkg::OPC_REG: begin
                ctrl.wen    = 1'b1;
                ctrl.alu_op = arith_op;
                if (!is_reg) begin
                    ctrl.b_sel = rv32_ex_pkg::B_IMM_I;
                end else if ((instr[31:25] & 7'b1011111) != 7'b0) begin
                    ctrl.illegal = 1'b1;
                end
            end
            rv32_ex_pkg::OPC_FENCE: ctrl.ifence = (funct3 == 3'b001);
            default: ctrl.illegal = 1'b1;
        endcase

        // all-ones word stops the core
        if (instr == '1) begin
            ctrl.wen     = 1'b0;
            ctrl.illegal = 1'b0;
            ctrl.halt    = 1'b1;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
/* integer register file, two combinational reads and one clocked write */
`timescale 1ns/1ns

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  rv32_ex_pkg::reg_idx_t rs1,
    input  rv32_ex_pkg::reg_idx_t rs2,
    input  rv32_ex_pkg::reg_idx_t rd,
    input  rv32_ex_pkg::word_t    w_data,
    input  logic                  wen,
    output rv32_ex_pkg::word_t    rs1_data,
    output rv32_ex_pkg::word_t    rs2_data
);

    rv32_ex_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0 && rd < NUM_REGS) begin
            regs[rd] <= w_data;
        end
    end

    // x0 and indices past the array read as zero
    assign rs1_data = (rs1 != '0 && rs1 < NUM_REGS) ? regs[rs1] : '0;
    assign rs2_data = (rs2 != '0 && rs2 < NUM_REGS) ? regs[rs2] : '0;

endmodule

// ==== rtl/alu.sv ====
/* RV32I integer ALU */
`timescale 1ns/1ns

module alu (
    input  rv32_ex_pkg::word_t   port_a,
    input  rv32_ex_pkg::word_t   port_b,
    input  rv32_ex_pkg::alu_op_t op,
    output rv32_ex_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = port_b[4:0];
    assign lt_signed   = $signed(port_a) < $signed(port_b);
    assign lt_unsigned = port_a < port_b;

    always_comb begin
        case (op)
            rv32_ex_pkg::ALU_ADD:  result = port_a + port_b;
            rv32_ex_pkg::ALU_SUB:  result = port_a - port_b;
            rv32_ex_pkg::ALU_SLL:  result = port_a << shamt;
            rv32_ex_pkg::ALU_SLT:  result = {31'b0, lt_signed};
            rv32_ex_pkg::ALU_SLTU: result = {31'b0, lt_unsigned};
            rv32_ex_pkg::ALU_XOR:  result = port_a ^ port_b;
            rv32_ex_pkg::ALU_SRL:  result = port_a >> shamt;
            rv32_ex_pkg::ALU_SRA:  result = $signed(port_a) >>> shamt;
            rv32_ex_pkg::ALU_OR:   result = port_a | port_b;
            rv32_ex_pkg::ALU_AND:  result = port_a & port_b;
            default:               result = '0;
        endcase
    end

endmodule

// ==== rtl/branch_res.sv ====
/* conditional branch resolver
   compares rs1 with rs2 by branch type and forms pc + offset */
`timescale 1ns/1ns

module branch_res (
    input  rv32_ex_pkg::word_t   rs1_data,
    input  rv32_ex_pkg::word_t   rs2_data,
    input  rv32_ex_pkg::word_t   pc,
    input  rv32_ex_pkg::word_t   imm_sb,
    input  rv32_ex_pkg::branch_t branch_type,
    output logic                 taken,
    output rv32_ex_pkg::word_t   addr
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = $signed(rs1_data) < $signed(rs2_data);
    assign ltu = rs1_data < rs2_data;

    always_comb begin
        case (branch_type)
            rv32_ex_pkg::BEQ:  taken = eq;
            rv32_ex_pkg::BNE:  taken = ~eq;
            rv32_ex_pkg::BLT:  taken = lt;
            rv32_ex_pkg::BGE:  taken = ~lt;
            rv32_ex_pkg::BLTU: taken = ltu;
            rv32_ex_pkg::BGEU: taken = ~ltu;
            default:           taken = 1'b0;
        endcase
    end

    assign addr = pc + imm_sb;

endmodule

// ==== rtl/dmem_lane.sv ====
/* data bus lane logic
   byte enables, store replication, alignment check and load extension */
`timescale 1ns/1ns

module dmem_lane #(
    parameter bit BIG_ENDIAN_BUS = 1'b1
) (
    input  rv32_ex_pkg::word_t    addr,
    input  rv32_ex_pkg::word_t    rs2_data,
    input  rv32_ex_pkg::word_t    rdata,
    input  rv32_ex_pkg::load_t    load_type,
    input  logic                  dren,
    input  logic                  dwen,
    output rv32_ex_pkg::byte_en_t byte_en,
    output rv32_ex_pkg::word_t    wdata,
    output logic                  mal,
    output rv32_ex_pkg::word_t    load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = rdata[addr[1:0]*8 +: 8];
    assign sel_half = addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        byte_en   = 4'b0000;
        wdata     = rs2_data;
        mal       = 1'b0;
        load_data = rdata;
        case (load_type)
            rv32_ex_pkg::LB, rv32_ex_pkg::LBU: begin
                byte_en   = 4'b0001 << addr[1:0];
                wdata     = {4{rs2_data[7:0]}};
                load_data = (load_type == rv32_ex_pkg::LB) ? {{24{sel_byte[7]}}, sel_byte}
                                                           : {24'b0, sel_byte};
            end
            rv32_ex_pkg::LH, rv32_ex_pkg::LHU: begin
                byte_en   = addr[1] ? 4'b1100 : 4'b0011;
                wdata     = {2{rs2_data[15:0]}};
                mal       = addr[0];
                load_data = (load_type == rv32_ex_pkg::LH) ? {{16{sel_half[15]}}, sel_half}
                                                           : {16'b0, sel_half};
            end
            default: begin
                byte_en   = 4'b1111;
                wdata     = rs2_data;
                mal       = (addr[1:0] != 2'b00);
                load_data = rdata;
            end
        endcase
        // little-endian bus sees load lanes in reverse order
        if (!BIG_ENDIAN_BUS && dren) begin
            byte_en = {byte_en[0], byte_en[1], byte_en[2], byte_en[3]};
        end
        if (!(dren || dwen)) begin
            mal = 1'b0;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
/* execute stage of the two-stage RV32I pipeline
   decode, register read, ALU, branch and jump resolution, data bus and write-back */
`timescale 1ns/1ns

module execute_stage #(
    parameter int NUM_REGS       = 32,
    parameter bit BIG_ENDIAN_BUS = 1'b1
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  rv32_ex_pkg::fetch_ex_t fetch_ex,
    input  logic                   if_ex_stall,
    output rv32_ex_pkg::dbus_req_t dbus_req,
    input  rv32_ex_pkg::word_t     dbus_rdata,
    input  logic                   dbus_busy,
    output rv32_ex_pkg::word_t     brj_addr,
    output logic                   mispredict,
    output logic                   halt,
    output rv32_ex_pkg::except_t   except,
    output logic                   d_mem_busy,
    output logic                   icache_flush,
    output logic                   dcache_flush,
    input  logic                   iflush_done,
    input  logic                   dflush_done,
    output logic                   fence_stall
);

    rv32_ex_pkg::ctrl_t    ctrl;
    rv32_ex_pkg::word_t    rs1_data;
    rv32_ex_pkg::word_t    rs2_data;
    rv32_ex_pkg::word_t    w_data;
    rv32_ex_pkg::word_t    port_a;
    rv32_ex_pkg::word_t    port_b;
    rv32_ex_pkg::word_t    alu_result;
    rv32_ex_pkg::word_t    br_addr;
    rv32_ex_pkg::word_t    jump_addr;
    rv32_ex_pkg::word_t    jalr_sum;
    rv32_ex_pkg::word_t    wdata;
    rv32_ex_pkg::word_t    load_data;
    rv32_ex_pkg::byte_en_t byte_en;
    logic                  rf_wen;
    logic                  br_taken;
    logic                  eff_taken;
    logic                  mal;
    logic                  mal_l;
    logic                  mal_s;
    logic                  ifence_reg;
    logic                  ifence_pulse;
    logic                  iflushed;
    logic                  dflushed;

    control_unit u_control_unit (
        .instr (fetch_ex.instr),
        .ctrl  (ctrl)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .CLK      (CLK),
        .nRST     (nRST),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rd       (ctrl.rd),
        .w_data   (w_data),
        .wen      (rf_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .port_a (port_a),
        .port_b (port_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    branch_res u_branch_res (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (fetch_ex.pc),
        .imm_sb      (ctrl.imm_sb),
        .branch_type (ctrl.branch_type),
        .taken       (br_taken),
        .addr        (br_addr)
    );

    dmem_lane #(
        .BIG_ENDIAN_BUS (BIG_ENDIAN_BUS)
    ) u_dmem_lane (
        .addr      (alu_result),
        .rs2_data  (rs2_data),
        .rdata     (dbus_rdata),
        .load_type (ctrl.load_type),
        .dren      (ctrl.dren),
        .dwen      (ctrl.dwen),
        .byte_en   (byte_en),
        .wdata     (wdata),
        .mal       (mal),
        .load_data (load_data)
    );

    always_comb begin
        case (ctrl.a_sel)
            rv32_ex_pkg::A_RS1:   port_a = rs1_data;
            rv32_ex_pkg::A_IMM_S: port_a = ctrl.imm_s;
            rv32_ex_pkg::A_PC:    port_a = fetch_ex.pc;
            default:              port_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.b_sel)
            rv32_ex_pkg::B_RS2:   port_b = rs2_data;
            rv32_ex_pkg::B_IMM_I: port_b = ctrl.imm_i;
            rv32_ex_pkg::B_IMM_U: port_b = ctrl.imm_u;
            default:              port_b = rs1_data;
        endcase
    end

    always_comb begin
        case (ctrl.w_sel)
            rv32_ex_pkg::W_LOAD:  w_data = load_data;
            rv32_ex_pkg::W_PC4:   w_data = fetch_ex.pc4;
            rv32_ex_pkg::W_IMM_U: w_data = ctrl.imm_u;
            default:              w_data = alu_result;
        endcase
    end

    assign mal_l = ctrl.dren & mal;
    assign mal_s = ctrl.dwen & mal;

    // memory ops write back only in the cycle the bus completes
    assign rf_wen = ctrl.wen & ~if_ex_stall & ~mal_l
                    & ~((ctrl.dren | ctrl.dwen) & dbus_busy);

    assign dbus_req.addr    = alu_result;
    assign dbus_req.wdata   = wdata;
    assign dbus_req.byte_en = byte_en;
    assign dbus_req.ren     = ctrl.dren & ~mal;
    assign dbus_req.wen     = ctrl.dwen & ~mal;
    assign d_mem_busy       = dbus_busy;

    // jalr target drops bit 0
    assign jalr_sum  = rs1_data + ctrl.imm_i;
    assign jump_addr = ctrl.j_sel ? (fetch_ex.pc + ctrl.imm_uj) : {jalr_sum[31:1], 1'b0};
    assign eff_taken = ctrl.jump | (ctrl.branch & br_taken);

    assign brj_addr   = ctrl.jump ? jump_addr : (eff_taken ? br_addr : fetch_ex.pc4);
    assign mispredict = fetch_ex.prediction ^ eff_taken;

    assign except.mal_l   = mal_l;
    assign except.mal_s   = mal_s;
    assign except.illegal = ctrl.illegal;
    assign except.badaddr = alu_result;

    // sticky until reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt <= 1'b0;
        end else if (ctrl.halt) begin
            halt <= 1'b1;
        end
    end

    // rising edge of ifence starts one flush of both caches
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_reg <= 1'b0;
        end else begin
            ifence_reg <= ctrl.ifence;
        end
    end

    assign ifence_pulse = ctrl.ifence & ~ifence_reg;
    assign icache_flush = ifence_pulse;
    assign dcache_flush = ifence_pulse;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iflushed <= 1'b1;
            dflushed <= 1'b1;
        end else begin
            if (ifence_pulse) begin
                iflushed <= 1'b0;
            end else if (iflush_done) begin
                iflushed <= 1'b1;
            end
            if (ifence_pulse) begin
                dflushed <= 1'b0;
            end else if (dflush_done) begin
                dflushed <= 1'b1;
            end
        end
    end

    // the pulse cycle itself stalls, the flags clear one edge later
    assign fence_stall = ctrl.ifence & (ifence_pulse | ~iflushed | ~dflushed);

endmodule

// ==== testbench/tb_execute_stage.sv ====
/* testbench for the RV32I execute stage
   replays instruction vectors, acts as data memory and as the cache flush responder */
`timescale 1ns/1ns

module tb_execute_stage;

    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_VEC = 20;

    typedef struct packed {
        rv32_ex_pkg::word_t    instr;
        rv32_ex_pkg::word_t    pc;
        rv32_ex_pkg::word_t    rdata;
        rv32_ex_pkg::word_t    addr;
        rv32_ex_pkg::word_t    wdata;
        rv32_ex_pkg::word_t    brj;
        logic [7:0]            busy;
        logic                  pred;
        logic                  mis;
        rv32_ex_pkg::byte_en_t be;
        logic [1:0]            rw;
        logic [2:0]            exc;
        logic [1:0]            flags;
    } vec_t;

    logic                   CLK;
    logic                   nRST;
    rv32_ex_pkg::fetch_ex_t fetch_ex;
    logic                   if_ex_stall;
    rv32_ex_pkg::dbus_req_t dbus_req;
    rv32_ex_pkg::word_t     dbus_rdata;
    logic                   dbus_busy;
    rv32_ex_pkg::word_t     brj_addr;
    logic                   mispredict;
    logic                   halt;
    rv32_ex_pkg::except_t   except;
    logic                   d_mem_busy;
    logic                   icache_flush;
    logic                   dcache_flush;
    logic                   iflush_done;
    logic                   dflush_done;
    logic                   fence_stall;

    vec_t        vecs[$];
    logic [31:0] rng_state   = 32'd89755;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    logic        halt_exp;

    execute_stage #(
        .NUM_REGS       (32),
        .BIG_ENDIAN_BUS (1'b1)
    ) u_execute_stage (
        .CLK          (CLK),
        .nRST         (nRST),
        .fetch_ex     (fetch_ex),
        .if_ex_stall  (if_ex_stall),
        .dbus_req     (dbus_req),
        .dbus_rdata   (dbus_rdata),
        .dbus_busy    (dbus_busy),
        .brj_addr     (brj_addr),
        .mispredict   (mispredict),
        .halt         (halt),
        .except       (except),
        .d_mem_busy   (d_mem_busy),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .fence_stall  (fence_stall)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the vectors did not complete", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 n;
        string              line;
        rv32_ex_pkg::word_t instr, pc, rdata, addr, wdata, brj;
        logic [31:0]        busy, pred, mis, be, rw, exc, flags;
        fd = $fopen("testbench/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file testbench/ex_vectors.txt");
            $display("*** FAILED ***");
            $fatal(1, "vector file missing");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %d %h %h %h %b %h %b %b %b",
                        instr, pc, pred, rdata, busy, addr, wdata, be, rw, brj, mis,
                        exc, flags);
            if (n == 13) begin
                vecs.push_back({instr, pc, rdata, addr, wdata, brj, busy[7:0], pred[0],
                                mis[0], be[3:0], rw[1:0], exc[2:0], flags[1:0]});
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("the vector file holds no usable vector lines");
            $display("*** FAILED ***");
            $fatal(1, "no vectors");
        end
        cycle_limit = CYCLES_PER_VEC * vecs.size() + RESET_CYCLES;
    endtask

    task automatic check_outputs(input vec_t v, input logic flush_exp, input logic stall_exp);
        check_value("dbus_req.ren", dbus_req.ren, v.rw[1]);
        check_value("dbus_req.wen", dbus_req.wen, v.rw[0]);
        if (v.rw != 2'b00) begin
            check_value("dbus_req.addr", dbus_req.addr, v.addr);
            check_value("dbus_req.byte_en", dbus_req.byte_en, v.be);
        end
        if (v.rw[0]) begin
            check_value("dbus_req.wdata", dbus_req.wdata, v.wdata);
        end
        check_value("brj_addr", brj_addr, v.brj);
        check_value("mispredict", mispredict, v.mis);
        check_value("except.mal_l", except.mal_l, v.exc[2]);
        check_value("except.mal_s", except.mal_s, v.exc[1]);
        check_value("except.illegal", except.illegal, v.exc[0]);
        if (v.exc[2] || v.exc[1]) begin
            check_value("except.badaddr", except.badaddr, v.addr);
        end
        check_value("d_mem_busy", d_mem_busy, dbus_busy);
        check_value("halt", halt, halt_exp);
        check_value("icache_flush", icache_flush, flush_exp);
        check_value("dcache_flush", dcache_flush, flush_exp);
        check_value("fence_stall", fence_stall, stall_exp);
    endtask

    task automatic run_step(input vec_t v);
        logic [31:0] rnd;
        int          busy_left;
        int          i_delay;
        int          d_delay;
        int          k;
        logic        i_seen;
        logic        d_seen;
        rnd       = lcg_next();
        busy_left = (v.rw != 2'b00) ? int'(v.busy) + int'(rnd[17:16]) : 0;
        @(negedge CLK);
        fetch_ex.instr      = v.instr;
        fetch_ex.pc         = v.pc;
        fetch_ex.pc4        = v.pc + 32'd4;
        fetch_ex.prediction = v.pred;
        // busy cycles carry a wrong data word so an early write would move the address
        while (busy_left > 0) begin
            dbus_busy  = 1'b1;
            dbus_rdata = ~v.rdata;
            #2;
            check_outputs(v, 1'b0, 1'b0);
            busy_left--;
            @(negedge CLK);
        end
        dbus_busy  = 1'b0;
        dbus_rdata = v.rdata;
        #2;
        check_outputs(v, v.flags[0], v.flags[0]);
        if (v.flags[0]) begin
            // flush responder answers each cache after its own delay
            rnd     = lcg_next();
            i_delay = 1 + int'(rnd[17:16]);
            d_delay = 1 + int'(rnd[19:18]);
            i_seen  = 1'b0;
            d_seen  = 1'b0;
            k       = 0;
            while (!(i_seen && d_seen)) begin
                @(negedge CLK);
                k++;
                iflush_done = (k == i_delay);
                dflush_done = (k == d_delay);
                #2;
                check_outputs(v, 1'b0, 1'b1);
                i_seen = i_seen | iflush_done;
                d_seen = d_seen | dflush_done;
            end
            @(negedge CLK);
            iflush_done = 1'b0;
            dflush_done = 1'b0;
            #2;
            check_outputs(v, 1'b0, 1'b0);
        end
        if (v.flags[1]) begin
            halt_exp = 1'b1;
        end
    endtask

    initial begin
        nRST           = 1'b0;
        fetch_ex       = '0;
        fetch_ex.instr = 32'h00000013;
        if_ex_stall    = 1'b0;
        dbus_rdata     = '0;
        dbus_busy      = 1'b0;
        iflush_done    = 1'b0;
        dflush_done    = 1'b0;
        halt_exp       = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        foreach (vecs[i]) begin
            run_step(vecs[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== testbench/ex_vectors.txt ====
// instr pc pred rdata busy(decimal) then expected addr wdata byte_en ren_wen brj_addr mispredict
// exc holds mal_l mal_s illegal and flags holds halt fence
123450b7 00000100 0 00000000 0 00000000 00000000 0 00 00000104 0 000 00
67808093 00000104 0 00000000 0 00000000 00000000 0 00 00000108 0 000 00
20000113 00000108 1 00000000 0 00000000 00000000 0 00 0000010c 1 000 00
ffb00193 0000010c 0 00000000 0 00000000 00000000 0 00 00000110 0 000 00
403082b3 00000110 0 00000000 0 00000000 00000000 0 00 00000114 0 000 00
00112083 00000114 0 00000000 0 00000201 00000000 0 00 00000118 0 100 00
00112123 00000118 0 00000000 0 00000202 00000000 0 00 0000011c 0 010 00
001110a3 0000011c 0 00000000 0 00000201 00000000 0 00 00000120 0 010 00
00311083 00000120 0 00000000 0 00000203 00000000 0 00 00000124 0 100 00
00112023 00000124 0 00000000 2 00000200 12345678 f 01 00000128 0 000 00
00312023 00000128 0 00000000 0 00000200 fffffffb f 01 0000012c 0 000 00
00512023 0000012c 0 00000000 0 00000200 1234567d f 01 00000130 0 000 00
0080026f 00000130 1 00000000 0 00000000 00000000 0 00 00000138 0 000 00
00412023 00000138 0 00000000 0 00000200 00000134 f 01 0000013c 0 000 00
00110023 0000013c 0 00000000 0 00000200 78787878 1 01 00000140 0 000 00
001100a3 00000140 0 00000000 0 00000201 78787878 2 01 00000144 0 000 00
00110123 00000144 0 00000000 0 00000202 78787878 4 01 00000148 0 000 00
001101a3 00000148 0 00000000 0 00000203 78787878 8 01 0000014c 0 000 00
00111023 0000014c 0 00000000 0 00000200 56785678 3 01 00000150 0 000 00
00111123 00000150 0 00000000 0 00000202 56785678 c 01 00000154 0 000 00
00010303 00000154 0 8091a2f3 0 00000200 00000000 1 10 00000158 0 000 00
00114383 00000158 0 8091a2f3 1 00000201 00000000 2 10 0000015c 0 000 00
00210403 0000015c 0 8091a2f3 0 00000202 00000000 4 10 00000160 0 000 00
00314483 00000160 0 8091a2f3 0 00000203 00000000 8 10 00000164 0 000 00
00011503 00000164 0 8091a2f3 0 00000200 00000000 3 10 00000168 0 000 00
00215583 00000168 0 8091a2f3 0 00000202 00000000 c 10 0000016c 0 000 00
00612023 0000016c 0 00000000 0 00000200 fffffff3 f 01 00000170 0 000 00
00712023 00000170 0 00000000 0 00000200 000000a2 f 01 00000174 0 000 00
00812023 00000174 0 00000000 0 00000200 ffffff91 f 01 00000178 0 000 00
00912023 00000178 0 00000000 0 00000200 00000080 f 01 0000017c 0 000 00
00a12023 0000017c 0 00000000 0 00000200 ffffa2f3 f 01 00000180 0 000 00
00b12023 00000180 0 00000000 0 00000200 00008091 f 01 00000184 0 000 00
24062603 00000184 0 cafef00d 3 00000240 00000000 f 10 00000188 0 000 00
00c12023 00000188 0 00000000 0 00000200 cafef00d f 01 0000018c 0 000 00
00108863 0000018c 1 00000000 0 00000000 00000000 0 00 0000019c 0 000 00
00309863 0000019c 0 00000000 0 00000000 00000000 0 00 000001ac 1 000 00
0011c863 000001ac 1 00000000 0 00000000 00000000 0 00 000001bc 0 000 00
0011d863 000001bc 1 00000000 0 00000000 00000000 0 00 000001c0 1 000 00
0011e863 000001c0 0 00000000 0 00000000 00000000 0 00 000001c4 0 000 00
0011f863 000001c4 0 00000000 0 00000000 00000000 0 00 000001d4 1 000 00
ffd08067 000001d4 0 00000000 0 00000000 00000000 0 00 12345674 1 000 00
0000100f 12345674 0 00000000 0 00000000 00000000 0 00 12345678 0 000 01
00000000 12345678 0 00000000 0 00000000 00000000 0 00 1234567c 0 001 00
ffffffff 1234567c 0 00000000 0 00000000 00000000 0 00 12345680 0 000 10
00000013 12345680 0 00000000 0 00000000 00000000 0 00 12345684 0 000 00

// ==== src.f ====
rtl/rv32_ex_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_res.sv
rtl/dmem_lane.sv
rtl/execute_stage.sv
testbench/tb_execute_stage.sv
